/* ctrlUnit.f */
hdl/ctrlPkg.sv
hdl/opDecode.sv
hdl/stepSequencer.sv
hdl/controlWordGen.sv
hdl/ctrlUnit.sv
test/ctrlUnit_props.sv
test/ctrlUnitTb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module ctrlUnitTb -f ctrlUnit.f -o ctrlUnitSim
	./obj_dir/ctrlUnitSim

clean:
	rm -rf obj_dir

/* test/ctrlUnitTb.sv */
`timescale 1ns/1ns

module ctrlUnitTb;

	localparam int InstrWidth = 32;
	localparam int TableSize = 21;
	// Longest instruction plus margin
	localparam int WaitLimit = 12;
	localparam int HaltCycles = 20;

	// conFf source: 0 low, 1 high, 2 random
	typedef struct {
		ctrlPkg::opcodeT     op;
		ctrlPkg::instrClassT kind;
		ctrlPkg::aluOpT      alu;
		int                  len;
		int                  con;
	} stimT;

	logic Clock;
	logic Reset;
	logic [InstrWidth-1:0] instrReg;
	logic conFf;
	ctrlPkg::controlWordT control;
	logic run;
	logic clear;

	logic [31:0] seed = 32'hc285_87e9;

	// --------------------------------------------------
	// Stimulus table
	// --------------------------------------------------
	stimT stimTable [TableSize] = '{
		'{ctrlPkg::OpAdd,  ctrlPkg::ClassAlu,    ctrlPkg::AluAdd,  6, 2},
		'{ctrlPkg::OpSub,  ctrlPkg::ClassAlu,    ctrlPkg::AluSub,  6, 2},
		'{ctrlPkg::OpShr,  ctrlPkg::ClassAlu,    ctrlPkg::AluShr,  6, 2},
		'{ctrlPkg::OpShra, ctrlPkg::ClassAlu,    ctrlPkg::AluShra, 6, 2},
		'{ctrlPkg::OpShl,  ctrlPkg::ClassAlu,    ctrlPkg::AluShl,  6, 2},
		'{ctrlPkg::OpRor,  ctrlPkg::ClassAlu,    ctrlPkg::AluRor,  6, 2},
		'{ctrlPkg::OpRol,  ctrlPkg::ClassAlu,    ctrlPkg::AluRol,  6, 2},
		'{ctrlPkg::OpAnd,  ctrlPkg::ClassAlu,    ctrlPkg::AluAnd,  6, 2},
		'{ctrlPkg::OpOr,   ctrlPkg::ClassAlu,    ctrlPkg::AluOr,   6, 2},
		'{ctrlPkg::OpAddi, ctrlPkg::ClassImm,    ctrlPkg::AluAdd,  6, 2},
		'{ctrlPkg::OpAndi, ctrlPkg::ClassImm,    ctrlPkg::AluAnd,  6, 2},
		'{ctrlPkg::OpOri,  ctrlPkg::ClassImm,    ctrlPkg::AluOr,   6, 2},
		'{ctrlPkg::OpNeg,  ctrlPkg::ClassUnary,  ctrlPkg::AluNeg,  5, 2},
		'{ctrlPkg::OpNot,  ctrlPkg::ClassUnary,  ctrlPkg::AluNot,  5, 2},
		'{ctrlPkg::OpBr,   ctrlPkg::ClassBranch, ctrlPkg::AluNone, 7, 1},
		'{ctrlPkg::OpBr,   ctrlPkg::ClassBranch, ctrlPkg::AluNone, 7, 0},
		'{ctrlPkg::OpBr,   ctrlPkg::ClassBranch, ctrlPkg::AluNone, 7, 2},
		'{ctrlPkg::OpNop,  ctrlPkg::ClassNop,    ctrlPkg::AluNone, 4, 2},
		// Undefined opcodes act as nop
		'{5'b00000,        ctrlPkg::ClassNop,    ctrlPkg::AluNone, 4, 2},
		'{5'b11111,        ctrlPkg::ClassNop,    ctrlPkg::AluNone, 4, 2},
		'{ctrlPkg::OpHalt, ctrlPkg::ClassHalt,   ctrlPkg::AluNone, 4, 2}
	};

	ctrlUnit #(
		.InstrWidth(InstrWidth)
	) DUT (
		.Clock   (Clock),
		.Reset   (Reset),
		.instrReg(instrReg),
		.conFf   (conFf),
		.control (control),
		.run     (run),
		.clear   (clear)
	);

	initial begin
		Clock = 1'b0;
		forever #4 Clock = ~Clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// --------------------------------------------------
	// Reference model, step 0 is fetch0
	// --------------------------------------------------
	function automatic ctrlPkg::controlWordT expectWord(input int idx, input stimT s,
			input logic cond);
		ctrlPkg::controlWordT w;
		w = '0;
		if (idx == 0) begin
			w.busOut.pcOut = 1'b1;
			w.latchIn.marIn = 1'b1;
			w.incPc = 1'b1;
			w.latchIn.zLowIn = 1'b1;
		end else if (idx == 1) begin
			w.busOut.zLowOut = 1'b1;
			w.latchIn.pcIn = 1'b1;
			w.mdRead = 1'b1;
			w.latchIn.mdrIn = 1'b1;
		end else if (idx == 2) begin
			w.busOut.mdrOut = 1'b1;
			w.latchIn.irIn = 1'b1;
		end else if (s.kind == ctrlPkg::ClassAlu || s.kind == ctrlPkg::ClassImm) begin
			if (idx == 3) begin
				w.regSel = ctrlPkg::SelGrb;
				w.busOut.regOut = 1'b1;
				w.latchIn.yIn = 1'b1;
			end else if (idx == 4) begin
				// Second operand from Rc or the constant
				if (s.kind == ctrlPkg::ClassAlu) begin
					w.regSel = ctrlPkg::SelGrc;
					w.busOut.regOut = 1'b1;
				end else begin
					w.busOut.cSignOut = 1'b1;
				end
				w.latchIn.zLowIn = 1'b1;
				w.aluOp = s.alu;
			end else if (idx == 5) begin
				w.busOut.zLowOut = 1'b1;
				w.regSel = ctrlPkg::SelGra;
				w.latchIn.regIn = 1'b1;
			end
		end else if (s.kind == ctrlPkg::ClassUnary) begin
			if (idx == 3) begin
				w.regSel = ctrlPkg::SelGrb;
				w.busOut.regOut = 1'b1;
				w.latchIn.zLowIn = 1'b1;
				w.aluOp = s.alu;
			end else if (idx == 4) begin
				w.busOut.zLowOut = 1'b1;
				w.regSel = ctrlPkg::SelGra;
				w.latchIn.regIn = 1'b1;
			end
		end else if (s.kind == ctrlPkg::ClassBranch) begin
			if (idx == 3) begin
				w.regSel = ctrlPkg::SelGra;
				w.busOut.regOut = 1'b1;
				w.latchIn.conIn = 1'b1;
			end else if (idx == 4) begin
				w.busOut.pcOut = 1'b1;
				w.latchIn.yIn = 1'b1;
			end else if (idx == 5) begin
				w.busOut.cSignOut = 1'b1;
				w.latchIn.zLowIn = 1'b1;
				w.aluOp = ctrlPkg::AluAdd;
			end else if (idx == 6) begin
				w.busOut.zLowOut = 1'b1;
				w.latchIn.pcIn = cond;
			end
		end
		return w;
	endfunction

	// --------------------------------------------------
	// Compare tasks
	// --------------------------------------------------
	task automatic checkControl(input ctrlPkg::controlWordT expected,
			input ctrlPkg::controlWordT actual);
		if (actual !== expected) begin
			$display("ERR %0t control expected %h got %h", $time, expected, actual);
			$display("Test failed");
			$fatal(1, "Control word mismatch");
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERR %0t %s expected %b got %b", $time, name, expected, actual);
			$display("Test failed");
			$fatal(1, "Status flag mismatch");
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("ERR %0t %s expected %0d got %0d", $time, name, expected, actual);
			$display("Test failed");
			$fatal(1, "Cycle count mismatch");
		end
	endtask

	// Sampled at the falling edge, counts extra cycles
	task automatic waitFetch0(output int cycles);
		cycles = 0;
		@(negedge Clock);
		while (!(control.busOut.pcOut && control.latchIn.marIn)) begin
			cycles++;
			if (cycles > WaitLimit) begin
				$display("Timed out waiting for the fetch0 control word");
				$display("Test failed");
				$fatal(1, "No fetch0 step");
			end
			@(negedge Clock);
		end
	endtask

	initial begin
		stimT s;
		int waited;
		int prevLen;
		logic cond;
		Reset = 1'b1;
		instrReg = '0;
		conFf = 1'b0;
		cond = 1'b0;
		repeat (4) @(posedge Clock);
		#1;
		Reset = 1'b0;

		// Reset step right after release
		@(negedge Clock);
		checkFlag("clear", 1'b1, clear);
		checkFlag("run", 1'b1, run);
		checkControl('0, control);
		prevLen = 1;

		for (int i = 0; i < TableSize; i++) begin
			s = stimTable[i];
			waitFetch0(waited);
			checkCount("cycles before fetch0", prevLen, prevLen + waited);
			checkControl(expectWord(0, s, cond), control);
			checkFlag("run", 1'b1, run);
			checkFlag("clear", 1'b0, clear);

			// New instruction during fetch1
			seed = xorshift(seed);
			cond = (s.con == 2) ? seed[31] : (s.con == 1);
			@(posedge Clock);
			#1;
			instrReg = {s.op, seed[26:0]};
			conFf = cond;
			for (int k = 1; k < s.len; k++) begin
				@(negedge Clock);
				checkControl(expectWord(k, s, cond), control);
				checkFlag("run", 1'b1, run);
				checkFlag("clear", 1'b0, clear);
			end
			prevLen = s.len;

			// Halted until reset
			if (s.kind == ctrlPkg::ClassHalt) begin
				repeat (HaltCycles) begin
					@(negedge Clock);
					checkFlag("run", 1'b0, run);
					checkFlag("clear", 1'b0, clear);
					checkControl('0, control);
				end
			end
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

/* test/ctrlUnit_props.sv */
`timescale 1ns/1ns

module ctrlUnitProps (
	input logic                 Clock,
	input logic                 Reset,
	input ctrlPkg::controlWordT control,
	input logic                 run,
	input logic                 clear,
	input logic                 conFf,
	input ctrlPkg::stepT        step,
	input ctrlPkg::decodedT     decoded
);

	// One driver on the bus at a time
	busSingleDriver: assert property (@(posedge Clock) disable iff (Reset)
		$onehot0(control.busOut))
		else $error("More than one bus driver active");

	// Halted means no strobes
	idleWhenStopped: assert property (@(posedge Clock) disable iff (Reset)
		!run |-> control == '0)
		else $error("Control word not zero while run is low");

	// A second clear cycle only while Reset was still high
	clearSingleCycle: assert property (@(posedge Clock) disable iff (Reset)
		clear && $past(clear) |-> $past(Reset))
		else $error("Clear held for more than one cycle");

	// PC loads outside fetch1 only in the last step of a taken branch
	branchNeedsCond: assert property (@(posedge Clock) disable iff (Reset)
		(control.latchIn.pcIn && step != ctrlPkg::StepFetch1)
			|-> (step == ctrlPkg::StepExec6
			&& decoded.instrClass == ctrlPkg::ClassBranch && conFf))
		else $error("PC loaded outside fetch1 without a taken branch");

endmodule

bind ctrlUnit ctrlUnitProps props (
	.Clock  (Clock),
	.Reset  (Reset),
	.control(control),
	.run    (run),
	.clear  (clear),
	.conFf  (conFf),
	.step   (step),
	.decoded(decoded)
);

/* hdl/ctrlUnit.sv */
`timescale 1ns/1ns

module ctrlUnit #(
	parameter int InstrWidth = 32
) (
	input  logic                  Clock,
	input  logic                  Reset,
	input  logic [InstrWidth-1:0] instrReg,
	input  logic                  conFf,
	output ctrlPkg::controlWordT  control,
	output logic                  run,
	output logic                  clear
);

	// Decoded opcode and current timing step
	ctrlPkg::decodedT decoded;
	ctrlPkg::stepT    step;

	opDecode #(
		.InstrWidth(InstrWidth)
	) decode (
		.instrReg(instrReg),
		.decoded (decoded)
	);

	// Owns instruction length
	stepSequencer sequencer (
		.Clock  (Clock),
		.Reset  (Reset),
		.decoded(decoded),
		.step   (step),
		.run    (run),
		.clear  (clear)
	);

	// Strobes for the datapath
	controlWordGen wordGen (
		.step   (step),
		.decoded(decoded),
		.conFf  (conFf),
		.control(control)
	);

endmodule

/* hdl/controlWordGen.sv */
`timescale 1ns/1ns

module controlWordGen (
	input  ctrlPkg::stepT        step,
	input  ctrlPkg::decodedT     decoded,
	input  logic                 conFf,
	output ctrlPkg::controlWordT control
);

	always_comb begin
		// Idle word, also for reset and halted steps
		control = '0;
		case (step)
			// --------------------------------------------------
			// Fetch
			// --------------------------------------------------
			// PC to MAR, PC plus one into Z
			ctrlPkg::StepFetch0: begin
				control.busOut.pcOut = 1'b1;
				control.latchIn.marIn = 1'b1;
				control.incPc = 1'b1;
				control.latchIn.zLowIn = 1'b1;
			end
			// Incremented PC back, memory read into MDR
			ctrlPkg::StepFetch1: begin
				control.busOut.zLowOut = 1'b1;
				control.latchIn.pcIn = 1'b1;
				control.mdRead = 1'b1;
				control.latchIn.mdrIn = 1'b1;
			end
			ctrlPkg::StepFetch2: begin
				control.busOut.mdrOut = 1'b1;
				control.latchIn.irIn = 1'b1;
			end
			// --------------------------------------------------
			// Execute
			// --------------------------------------------------
			ctrlPkg::StepExec3: begin
				case (decoded.instrClass)
					// First operand Rb into Y
					ctrlPkg::ClassAlu, ctrlPkg::ClassImm: begin
						control.regSel = ctrlPkg::SelGrb;
						control.busOut.regOut = 1'b1;
						control.latchIn.yIn = 1'b1;
					end
					// Rb straight through the ALU
					ctrlPkg::ClassUnary: begin
						control.regSel = ctrlPkg::SelGrb;
						control.busOut.regOut = 1'b1;
						control.latchIn.zLowIn = 1'b1;
						control.aluOp = decoded.aluOp;
					end
					// Ra to the condition logic
					ctrlPkg::ClassBranch: begin
						control.regSel = ctrlPkg::SelGra;
						control.busOut.regOut = 1'b1;
						control.latchIn.conIn = 1'b1;
					end
					default: ;
				endcase
			end
			ctrlPkg::StepExec4: begin
				case (decoded.instrClass)
					ctrlPkg::ClassAlu: begin
						control.regSel = ctrlPkg::SelGrc;
						control.busOut.regOut = 1'b1;
						control.latchIn.zLowIn = 1'b1;
						control.aluOp = decoded.aluOp;
					end
					// Sign extended constant as second operand
					ctrlPkg::ClassImm: begin
						control.busOut.cSignOut = 1'b1;
						control.latchIn.zLowIn = 1'b1;
						control.aluOp = decoded.aluOp;
					end
					// Unary result into Ra
					ctrlPkg::ClassUnary: begin
						control.busOut.zLowOut = 1'b1;
						control.regSel = ctrlPkg::SelGra;
						control.latchIn.regIn = 1'b1;
					end
					// PC into Y for the target add
					ctrlPkg::ClassBranch: begin
						control.busOut.pcOut = 1'b1;
						control.latchIn.yIn = 1'b1;
					end
					default: ;
				endcase
			end
			ctrlPkg::StepExec5: begin
				case (decoded.instrClass)
					// Write back into Ra
					ctrlPkg::ClassAlu, ctrlPkg::ClassImm: begin
						control.busOut.zLowOut = 1'b1;
						control.regSel = ctrlPkg::SelGra;
						control.latchIn.regIn = 1'b1;
					end
					// PC plus offset
					ctrlPkg::ClassBranch: begin
						control.busOut.cSignOut = 1'b1;
						control.latchIn.zLowIn = 1'b1;
						control.aluOp = ctrlPkg::AluAdd;
					end
					default: ;
				endcase
			end
			// Target loads into PC only when taken
			ctrlPkg::StepExec6: begin
				if (decoded.instrClass == ctrlPkg::ClassBranch) begin
					control.busOut.zLowOut = 1'b1;
					control.latchIn.pcIn = conFf;
				end
			end
			default: ;
		endcase
	end

endmodule

/* hdl/stepSequencer.sv */
`timescale 1ns/1ns

module stepSequencer (
	input  logic             Clock,
	input  logic             Reset,
	input  ctrlPkg::decodedT decoded,
	output ctrlPkg::stepT    step,
	output logic             run,
	output logic             clear
);

	ctrlPkg::stepT nextStep;

	// --------------------------------------------------
	// Step register
	// --------------------------------------------------
	always_ff @(posedge Clock, posedge Reset) begin
		if (Reset) begin
			step <= ctrlPkg::StepReset;
		end else begin
			step <= nextStep;
		end
	end

	// --------------------------------------------------
	// Next step
	// --------------------------------------------------
	always_comb begin
		nextStep = ctrlPkg::StepReset;
		case (step)
			ctrlPkg::StepReset: nextStep = ctrlPkg::StepFetch0;
			// Fetch is the same for every instruction
			ctrlPkg::StepFetch0: nextStep = ctrlPkg::StepFetch1;
			ctrlPkg::StepFetch1: nextStep = ctrlPkg::StepFetch2;
			ctrlPkg::StepFetch2: nextStep = ctrlPkg::StepExec3;
			// Nop and halt end after one execute step
			ctrlPkg::StepExec3: begin
				case (decoded.instrClass)
					ctrlPkg::ClassNop: nextStep = ctrlPkg::StepFetch0;
					ctrlPkg::ClassHalt: nextStep = ctrlPkg::StepHalted;
					default: nextStep = ctrlPkg::StepExec4;
				endcase
			end
			// Unary writes back in Exec4
			ctrlPkg::StepExec4: begin
				if (decoded.instrClass == ctrlPkg::ClassUnary) begin
					nextStep = ctrlPkg::StepFetch0;
				end else begin
					nextStep = ctrlPkg::StepExec5;
				end
			end
			// Only branch needs a fourth execute step
			ctrlPkg::StepExec5: begin
				if (decoded.instrClass == ctrlPkg::ClassBranch) begin
					nextStep = ctrlPkg::StepExec6;
				end else begin
					nextStep = ctrlPkg::StepFetch0;
				end
			end
			ctrlPkg::StepExec6: nextStep = ctrlPkg::StepFetch0;
			// Stuck here until the next reset
			ctrlPkg::StepHalted: nextStep = ctrlPkg::StepHalted;
			default: nextStep = ctrlPkg::StepReset;
		endcase
	end

	// --------------------------------------------------
	// Status outputs
	// --------------------------------------------------
	// Clear pulses for the reset step only
	assign clear = (step == ctrlPkg::StepReset);
	assign run = (step != ctrlPkg::StepHalted);

endmodule

/* hdl/opDecode.sv */
`timescale 1ns/1ns

module opDecode #(
	parameter int InstrWidth = 32
) (
	input  logic [InstrWidth-1:0] instrReg,
	output ctrlPkg::decodedT      decoded
);

	// Opcode sits in the top five bits
	ctrlPkg::opcodeT opcode;

	assign opcode = instrReg[InstrWidth-1 -: 5];

	// --------------------------------------------------
	// Opcode lookup
	// --------------------------------------------------
	always_comb begin
		// Anything unlisted falls through as a nop
		decoded.instrClass = ctrlPkg::ClassNop;
		decoded.aluOp = ctrlPkg::AluNone;
		case (opcode)
			// Two register operands
			ctrlPkg::OpAdd: begin
				decoded.instrClass = ctrlPkg::ClassAlu;
				decoded.aluOp = ctrlPkg::AluAdd;
			end
			ctrlPkg::OpSub: begin
				decoded.instrClass = ctrlPkg::ClassAlu;
				decoded.aluOp = ctrlPkg::AluSub;
			end
			ctrlPkg::OpShr: begin
				decoded.instrClass = ctrlPkg::ClassAlu;
				decoded.aluOp = ctrlPkg::AluShr;
			end
			ctrlPkg::OpShra: begin
				decoded.instrClass = ctrlPkg::ClassAlu;
				decoded.aluOp = ctrlPkg::AluShra;
			end
			ctrlPkg::OpShl: begin
				decoded.instrClass = ctrlPkg::ClassAlu;
				decoded.aluOp = ctrlPkg::AluShl;
			end
			ctrlPkg::OpRor: begin
				decoded.instrClass = ctrlPkg::ClassAlu;
				decoded.aluOp = ctrlPkg::AluRor;
			end
			ctrlPkg::OpRol: begin
				decoded.instrClass = ctrlPkg::ClassAlu;
				decoded.aluOp = ctrlPkg::AluRol;
			end
			ctrlPkg::OpAnd: begin
				decoded.instrClass = ctrlPkg::ClassAlu;
				decoded.aluOp = ctrlPkg::AluAnd;
			end
			ctrlPkg::OpOr: begin
				decoded.instrClass = ctrlPkg::ClassAlu;
				decoded.aluOp = ctrlPkg::AluOr;
			end
			// Constant from the C field
			ctrlPkg::OpAddi: begin
				decoded.instrClass = ctrlPkg::ClassImm;
				decoded.aluOp = ctrlPkg::AluAdd;
			end
			ctrlPkg::OpAndi: begin
				decoded.instrClass = ctrlPkg::ClassImm;
				decoded.aluOp = ctrlPkg::AluAnd;
			end
			ctrlPkg::OpOri: begin
				decoded.instrClass = ctrlPkg::ClassImm;
				decoded.aluOp = ctrlPkg::AluOr;
			end
			// Single source operand
			ctrlPkg::OpNeg: begin
				decoded.instrClass = ctrlPkg::ClassUnary;
				decoded.aluOp = ctrlPkg::AluNeg;
			end
			ctrlPkg::OpNot: begin
				decoded.instrClass = ctrlPkg::ClassUnary;
				decoded.aluOp = ctrlPkg::AluNot;
			end
			// Branch adds its offset in Exec5, not here
			ctrlPkg::OpBr: decoded.instrClass = ctrlPkg::ClassBranch;
			ctrlPkg::OpNop: decoded.instrClass = ctrlPkg::ClassNop;
			ctrlPkg::OpHalt: decoded.instrClass = ctrlPkg::ClassHalt;
			default: ;
		endcase
	end

endmodule

/* hdl/ctrlPkg.sv */
package ctrlPkg;

	// --------------------------------------------------
	// Opcode field
	// --------------------------------------------------
	typedef logic [4:0] opcodeT;

	// Register to register ALU group
	localparam opcodeT OpAdd  = 5'b00011;
	localparam opcodeT OpSub  = 5'b00100;
	localparam opcodeT OpShr  = 5'b00101;
	localparam opcodeT OpShra = 5'b00110;
	localparam opcodeT OpShl  = 5'b00111;
	localparam opcodeT OpRor  = 5'b01000;
	localparam opcodeT OpRol  = 5'b01001;
	localparam opcodeT OpAnd  = 5'b01010;
	localparam opcodeT OpOr   = 5'b01011;
	// Immediate group
	localparam opcodeT OpAddi = 5'b01100;
	localparam opcodeT OpAndi = 5'b01101;
	localparam opcodeT OpOri  = 5'b01110;
	// Unary, branch and misc
	localparam opcodeT OpNeg  = 5'b10001;
	localparam opcodeT OpNot  = 5'b10010;
	localparam opcodeT OpBr   = 5'b10011;
	localparam opcodeT OpNop  = 5'b11010;
	localparam opcodeT OpHalt = 5'b11011;

	// --------------------------------------------------
	// Decoded instruction
	// --------------------------------------------------
	typedef logic [2:0] instrClassT;

	localparam instrClassT ClassAlu    = 3'd0;
	localparam instrClassT ClassImm    = 3'd1;
	localparam instrClassT ClassUnary  = 3'd2;
	localparam instrClassT ClassBranch = 3'd3;
	localparam instrClassT ClassNop    = 3'd4;
	localparam instrClassT ClassHalt   = 3'd5;

	typedef logic [3:0] aluOpT;

	localparam aluOpT AluNone = 4'd0;
	localparam aluOpT AluAdd  = 4'd1;
	localparam aluOpT AluSub  = 4'd2;
	localparam aluOpT AluAnd  = 4'd3;
	localparam aluOpT AluOr   = 4'd4;
	localparam aluOpT AluShr  = 4'd5;
	localparam aluOpT AluShra = 4'd6;
	localparam aluOpT AluShl  = 4'd7;
	localparam aluOpT AluRor  = 4'd8;
	localparam aluOpT AluRol  = 4'd9;
	localparam aluOpT AluNeg  = 4'd10;
	localparam aluOpT AluNot  = 4'd11;

	typedef struct packed {
		instrClassT instrClass;
		aluOpT      aluOp;
	} decodedT;

	// Timing steps, one clock each
	typedef enum logic [3:0] {
		StepReset,
		StepFetch0,
		StepFetch1,
		StepFetch2,
		StepExec3,
		StepExec4,
		StepExec5,
		StepExec6,
		StepHalted
	} stepT;

	// --------------------------------------------------
	// Control word
	// --------------------------------------------------
	// Register field selects, gra in the top bit
	typedef logic [2:0] regSelT;

	localparam regSelT SelGra = 3'b100;
	localparam regSelT SelGrb = 3'b010;
	localparam regSelT SelGrc = 3'b001;

	// Bus drivers
	typedef struct packed {
		logic pcOut;
		logic mdrOut;
		logic zLowOut;
		logic regOut;
		logic cSignOut;
	} busOutT;

	// Register load enables
	typedef struct packed {
		logic pcIn;
		logic irIn;
		logic marIn;
		logic mdrIn;
		logic yIn;
		logic zLowIn;
		logic regIn;
		logic conIn;
	} latchInT;

	typedef struct packed {
		busOutT  busOut;
		latchInT latchIn;
		regSelT  regSel;
		aluOpT   aluOp;
		logic    incPc;
		logic    mdRead;
	} controlWordT;

endpackage
